// File: logic/fpu_mul_pkg.sv
package fpu_mul_pkg;

  // default binary32 field layout, overridden from the top level
  localparam int FmtExpWidth = 8;
  localparam int FmtSigWidth = 23;

  // one packed IEEE value, also the AXI data width
  typedef logic [31:0] fp_word_t;

  // register byte address on the AXI4-Lite port
  typedef logic [3:0] axil_addr_t;

  // exception flags of one result
  typedef logic [3:0] fp_flags_t;

  typedef logic [1:0] axil_resp_t;

  // flag bit positions inside fp_flags_t
  localparam int FlagNx = 0;
  localparam int FlagUf = 1;
  localparam int FlagOf = 2;
  localparam int FlagNv = 3;

  localparam axil_resp_t RespOkay   = 2'b00;
  localparam axil_resp_t RespSlverr = 2'b10;

  // register map
  localparam axil_addr_t RegOpA    = 4'h0;
  localparam axil_addr_t RegOpB    = 4'h4;
  localparam axil_addr_t RegResult = 4'h8;
  // bit 0 busy, bits 4:1 flags of the last result
  localparam axil_addr_t RegStatus = 4'hC;

  // the only NaN the datapath ever produces
  localparam fp_word_t CanonicalNan = 32'h7FC0_0000;

endpackage

// File: logic/fpu_unpack.sv
module fpu_unpack import fpu_mul_pkg::*; #(
  parameter int FmtExpWidth = fpu_mul_pkg::FmtExpWidth,
  parameter int FmtSigWidth = fpu_mul_pkg::FmtSigWidth
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          start_i,
  input  fp_word_t                      op_a_i,
  input  fp_word_t                      op_b_i,

  output logic                          valid_o,

  output logic                          a_sign_o,
  output logic signed [FmtExpWidth:0]   a_exponent_o,
  output logic        [FmtSigWidth-1:0] a_significand_o,
  output logic                          a_is_zero_o,
  output logic                          a_is_inf_o,
  output logic                          a_is_nan_o,

  output logic                          b_sign_o,
  output logic signed [FmtExpWidth:0]   b_exponent_o,
  output logic        [FmtSigWidth-1:0] b_significand_o,
  output logic                          b_is_zero_o,
  output logic                          b_is_inf_o,
  output logic                          b_is_nan_o
);

  localparam int Bias = 2 ** (FmtExpWidth - 1) - 1;

  logic [FmtExpWidth-1:0] a_field;
  logic [FmtExpWidth-1:0] b_field;
  logic [FmtSigWidth-1:0] a_frac;
  logic [FmtSigWidth-1:0] b_frac;
  logic                   a_exp_ones;
  logic                   b_exp_ones;

  assign a_field = op_a_i[FmtSigWidth +: FmtExpWidth];
  assign b_field = op_b_i[FmtSigWidth +: FmtExpWidth];
  assign a_frac  = op_a_i[FmtSigWidth-1:0];
  assign b_frac  = op_b_i[FmtSigWidth-1:0];

  assign a_exp_ones = &a_field;
  assign b_exp_ones = &b_field;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= start_i;
    end
  end

  // fields are only captured when an operation enters
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      a_sign_o        <= op_a_i[FmtExpWidth+FmtSigWidth];
      a_exponent_o    <= {1'b0, a_field} - (FmtExpWidth+1)'(Bias);
      a_significand_o <= a_frac;
      // subnormals are treated as zero
      a_is_zero_o     <= (a_field == '0);
      a_is_inf_o      <= a_exp_ones && (a_frac == '0);
      a_is_nan_o      <= a_exp_ones && (a_frac != '0);

      b_sign_o        <= op_b_i[FmtExpWidth+FmtSigWidth];
      b_exponent_o    <= {1'b0, b_field} - (FmtExpWidth+1)'(Bias);
      b_significand_o <= b_frac;
      b_is_zero_o     <= (b_field == '0);
      b_is_inf_o      <= b_exp_ones && (b_frac == '0);
      b_is_nan_o      <= b_exp_ones && (b_frac != '0);
    end
  end

endmodule

// File: logic/fpu_mul.sv
module fpu_mul #(
  parameter int FmtExpWidth = fpu_mul_pkg::FmtExpWidth,
  parameter int FmtSigWidth = fpu_mul_pkg::FmtSigWidth
) (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            valid_i,

  input  logic                            a_sign_i,
  input  logic signed [FmtExpWidth:0]     a_exponent_i,
  input  logic        [FmtSigWidth-1:0]   a_significand_i,
  input  logic                            a_is_zero_i,
  input  logic                            a_is_inf_i,
  input  logic                            a_is_nan_i,

  input  logic                            b_sign_i,
  input  logic signed [FmtExpWidth:0]     b_exponent_i,
  input  logic        [FmtSigWidth-1:0]   b_significand_i,
  input  logic                            b_is_zero_i,
  input  logic                            b_is_inf_i,
  input  logic                            b_is_nan_i,

  output logic                            valid_o,
  output logic                            invalid_o,
  output logic                            sign_o,
  output logic signed [FmtExpWidth+1:0]   exponent_o,
  output logic        [2*FmtSigWidth:0]   significand_o,
  output logic                            is_zero_o,
  output logic                            is_inf_o,
  output logic                            is_nan_o
);

  logic                          a_snan;
  logic                          b_snan;
  logic                          inf_times_zero;
  logic                          nan_d;
  logic                          inf_d;
  logic signed [FmtExpWidth+1:0] exp_sum;
  logic [2*FmtSigWidth+1:0]      sig_prod;
  logic                          prod_hi;

  // a quiet NaN has the top fraction bit set
  assign a_snan = a_is_nan_i && !a_significand_i[FmtSigWidth-1];
  assign b_snan = b_is_nan_i && !b_significand_i[FmtSigWidth-1];
  assign inf_times_zero = (a_is_inf_i && b_is_zero_i) || (a_is_zero_i && b_is_inf_i);

  // inf times zero becomes a NaN so the three classes stay exclusive
  assign nan_d = a_is_nan_i || b_is_nan_i || inf_times_zero;
  assign inf_d = !nan_d && (a_is_inf_i || b_is_inf_i);

  assign exp_sum  = a_exponent_i + b_exponent_i;
  // product of two values in [1,2) lies in [1,4)
  assign sig_prod = {1'b1, a_significand_i} * {1'b1, b_significand_i};
  assign prod_hi  = sig_prod[2*FmtSigWidth+1];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      invalid_o  <= a_snan || b_snan || inf_times_zero;
      sign_o     <= a_sign_i ^ b_sign_i;
      is_nan_o   <= nan_d;
      is_inf_o   <= inf_d;
      is_zero_o  <= !nan_d && !inf_d && (a_is_zero_i || b_is_zero_i);
      exponent_o <= exp_sum + (FmtExpWidth+2)'(prod_hi);
      // drop the leading one, shifting up when the product is below 2
      significand_o <= prod_hi ? sig_prod[2*FmtSigWidth:0]
                               : {sig_prod[2*FmtSigWidth-1:0], 1'b0};
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_o |-> $onehot0({is_zero_o, is_inf_o, is_nan_o}))
  else $error("fpu_mul result class is not exclusive");

endmodule

// File: logic/fpu_round_pack.sv
module fpu_round_pack import fpu_mul_pkg::*; #(
  parameter int FmtExpWidth = fpu_mul_pkg::FmtExpWidth,
  parameter int FmtSigWidth = fpu_mul_pkg::FmtSigWidth
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          valid_i,
  input  logic                          invalid_i,
  input  logic                          sign_i,
  input  logic signed [FmtExpWidth+1:0] exponent_i,
  input  logic        [2*FmtSigWidth:0] significand_i,
  input  logic                          is_zero_i,
  input  logic                          is_inf_i,
  input  logic                          is_nan_i,

  output logic                          done_o,
  output fp_word_t                      result_o,
  output fp_flags_t                     flags_o
);

  localparam int Bias   = 2 ** (FmtExpWidth - 1) - 1;
  localparam int ExpMax = 2 ** FmtExpWidth - 1;

  // quiet NaN with an empty payload in the configured format
  localparam fp_word_t NanWord =
    fp_word_t'({1'b0, {FmtExpWidth{1'b1}}, 1'b1, {(FmtSigWidth-1){1'b0}}});

  logic [FmtSigWidth-1:0]        frac_trunc;
  logic                          guard;
  logic                          sticky;
  logic                          round_up;
  logic [FmtSigWidth:0]          frac_round;
  logic signed [FmtExpWidth+1:0] exp_biased;
  fp_word_t                      result_d;
  fp_flags_t                     flags_d;

  assign frac_trunc = significand_i[2*FmtSigWidth:FmtSigWidth+1];
  assign guard      = significand_i[FmtSigWidth];
  assign sticky     = |significand_i[FmtSigWidth-1:0];

  // nearest, ties to even
  assign round_up   = guard && (sticky || frac_trunc[0]);
  assign frac_round = {1'b0, frac_trunc} + (FmtSigWidth+1)'(round_up);

  // a carry out of the fraction leaves it all zero and bumps the exponent
  assign exp_biased = exponent_i + (FmtExpWidth+2)'(Bias)
                    + (FmtExpWidth+2)'(frac_round[FmtSigWidth]);

  always_comb begin
    result_d = '0;
    flags_d  = '0;
    if (is_nan_i || invalid_i) begin
      result_d        = NanWord;
      flags_d[FlagNv] = invalid_i;
    end else if (is_inf_i) begin
      result_d = fp_word_t'({sign_i, {FmtExpWidth{1'b1}}, {FmtSigWidth{1'b0}}});
    end else if (is_zero_i) begin
      result_d = fp_word_t'({sign_i, {(FmtExpWidth+FmtSigWidth){1'b0}}});
    end else if (exp_biased >= ExpMax) begin
      result_d        = fp_word_t'({sign_i, {FmtExpWidth{1'b1}}, {FmtSigWidth{1'b0}}});
      flags_d[FlagOf] = 1'b1;
      flags_d[FlagNx] = 1'b1;
    end else if (exp_biased < 1) begin
      // no gradual underflow, flush to signed zero
      result_d        = fp_word_t'({sign_i, {(FmtExpWidth+FmtSigWidth){1'b0}}});
      flags_d[FlagUf] = 1'b1;
      flags_d[FlagNx] = 1'b1;
    end else begin
      result_d = fp_word_t'({sign_i, exp_biased[FmtExpWidth-1:0],
                             frac_round[FmtSigWidth-1:0]});
      flags_d[FlagNx] = guard || sticky;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      done_o <= 1'b0;
    end else begin
      done_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o <= result_d;
      flags_o  <= flags_d;
    end
  end

  // any NaN leaving the pipeline must be the canonical one
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_o && (&result_o[FmtSigWidth +: FmtExpWidth]) && (|result_o[FmtSigWidth-1:0])
    |-> result_o == NanWord)
  else $error("non-canonical NaN at the pipeline output");

endmodule

// File: logic/fpu_mul_axil_regs.sv
module fpu_mul_axil_regs import fpu_mul_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,

  input  axil_addr_t s_awaddr_i,
  input  logic       s_awvalid_i,
  output logic       s_awready_o,
  input  fp_word_t   s_wdata_i,
  input  logic [3:0] s_wstrb_i,
  input  logic       s_wvalid_i,
  output logic       s_wready_o,
  output axil_resp_t s_bresp_o,
  output logic       s_bvalid_o,
  input  logic       s_bready_i,
  input  axil_addr_t s_araddr_i,
  input  logic       s_arvalid_i,
  output logic       s_arready_o,
  output fp_word_t   s_rdata_o,
  output axil_resp_t s_rresp_o,
  output logic       s_rvalid_o,
  input  logic       s_rready_i,

  input  logic       done_i,
  input  fp_word_t   result_i,
  input  fp_flags_t  flags_i,

  output logic       start_o,
  output fp_word_t   op_a_o,
  output fp_word_t   op_b_o
);

  logic       wr_fire;
  logic       wr_op_a;
  logic       wr_op_b;
  logic       rd_fire;
  logic       busy;
  logic [2:0] inflight_q;
  fp_word_t   result_q;
  fp_flags_t  flags_q;
  fp_word_t   rdata_d;
  axil_resp_t rresp_d;

  function automatic fp_word_t apply_strb(fp_word_t old_val, fp_word_t new_val,
                                          logic [3:0] strb);
    fp_word_t merged;
    merged = old_val;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        merged[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // AW and W are taken together, and only while no B response waits
  assign wr_fire     = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
  assign s_awready_o = wr_fire;
  assign s_wready_o  = wr_fire;
  assign wr_op_a     = wr_fire && (s_awaddr_i == RegOpA);
  assign wr_op_b     = wr_fire && (s_awaddr_i == RegOpB);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      op_a_o <= '0;
      op_b_o <= '0;
    end else begin
      if (wr_op_a) begin
        op_a_o <= apply_strb(op_a_o, s_wdata_i, s_wstrb_i);
      end
      if (wr_op_b) begin
        op_b_o <= apply_strb(op_b_o, s_wdata_i, s_wstrb_i);
      end
    end
  end

  // start and the B response both appear the cycle after the handshake
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      start_o    <= 1'b0;
      s_bvalid_o <= 1'b0;
      s_bresp_o  <= RespOkay;
    end else begin
      start_o <= wr_op_b;
      if (wr_fire) begin
        s_bvalid_o <= 1'b1;
        s_bresp_o  <= (wr_op_a || wr_op_b) ? RespOkay : RespSlverr;
      end else if (s_bready_i) begin
        s_bvalid_o <= 1'b0;
      end
    end
  end

  // operations in flight, at most two given the bus turnaround
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      inflight_q <= '0;
      result_q   <= '0;
      flags_q    <= '0;
    end else begin
      inflight_q <= inflight_q + 3'(start_o) - 3'(done_i);
      if (done_i) begin
        result_q <= result_i;
        flags_q  <= flags_i;
      end
    end
  end

  assign busy = (inflight_q != '0);

  assign s_arready_o = !s_rvalid_o;
  assign rd_fire     = s_arvalid_i && s_arready_o;

  always_comb begin
    rdata_d = '0;
    rresp_d = RespOkay;
    case (s_araddr_i)
      RegOpA:    rdata_d = op_a_o;
      RegOpB:    rdata_d = op_b_o;
      RegResult: rdata_d = result_q;
      RegStatus: rdata_d = fp_word_t'({flags_q, busy});
      default:   rresp_d = RespSlverr;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s_rvalid_o <= 1'b0;
      s_rdata_o  <= '0;
      s_rresp_o  <= RespOkay;
    end else begin
      if (rd_fire) begin
        s_rvalid_o <= 1'b1;
        s_rdata_o  <= rdata_d;
        s_rresp_o  <= rresp_d;
      end else if (s_rready_i) begin
        s_rvalid_o <= 1'b0;
      end
    end
  end

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_bvalid_o && !s_bready_i |=> s_bvalid_o && $stable(s_bresp_o))
  else $error("B response changed before bready");

  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    s_rvalid_o && !s_rready_i |=> s_rvalid_o && $stable(s_rdata_o) && $stable(s_rresp_o))
  else $error("R response changed before rready");

  // every done from the pipeline must match an earlier start
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    done_i |-> inflight_q != '0)
  else $error("in-flight counter underflow");

endmodule

// File: logic/fpu_mul_top.sv
module fpu_mul_top import fpu_mul_pkg::*; #(
  parameter int FmtExpWidth = fpu_mul_pkg::FmtExpWidth,
  parameter int FmtSigWidth = fpu_mul_pkg::FmtSigWidth
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  axil_addr_t s_awaddr_i,
  input  logic       s_awvalid_i,
  output logic       s_awready_o,
  input  fp_word_t   s_wdata_i,
  input  logic [3:0] s_wstrb_i,
  input  logic       s_wvalid_i,
  output logic       s_wready_o,
  output axil_resp_t s_bresp_o,
  output logic       s_bvalid_o,
  input  logic       s_bready_i,
  input  axil_addr_t s_araddr_i,
  input  logic       s_arvalid_i,
  output logic       s_arready_o,
  output fp_word_t   s_rdata_o,
  output axil_resp_t s_rresp_o,
  output logic       s_rvalid_o,
  input  logic       s_rready_i
);

  logic start, unpack_valid, mul_valid, done;
  fp_word_t op_a, op_b, result;
  fp_flags_t flags;

  logic a_sign, a_is_zero, a_is_inf, a_is_nan;
  logic b_sign, b_is_zero, b_is_inf, b_is_nan;
  logic signed [FmtExpWidth:0] a_exponent, b_exponent;
  logic [FmtSigWidth-1:0] a_significand, b_significand;

  logic mul_invalid, mul_sign, mul_is_zero, mul_is_inf, mul_is_nan;
  logic signed [FmtExpWidth+1:0] mul_exponent;
  logic [2*FmtSigWidth:0] mul_significand;

  fpu_mul_axil_regs fpu_mul_axil_regs_inst (
    .clk_i, .rst_n_i,
    .s_awaddr_i, .s_awvalid_i, .s_awready_o,
    .s_wdata_i, .s_wstrb_i, .s_wvalid_i, .s_wready_o,
    .s_bresp_o, .s_bvalid_o, .s_bready_i,
    .s_araddr_i, .s_arvalid_i, .s_arready_o,
    .s_rdata_o, .s_rresp_o, .s_rvalid_o, .s_rready_i,
    .done_i(done), .result_i(result), .flags_i(flags),
    .start_o(start), .op_a_o(op_a), .op_b_o(op_b)
  );

  fpu_unpack #(.FmtExpWidth(FmtExpWidth), .FmtSigWidth(FmtSigWidth)) fpu_unpack_inst (
    .clk_i, .rst_n_i, .start_i(start), .op_a_i(op_a), .op_b_i(op_b),
    .valid_o(unpack_valid),
    .a_sign_o(a_sign), .a_exponent_o(a_exponent), .a_significand_o(a_significand),
    .a_is_zero_o(a_is_zero), .a_is_inf_o(a_is_inf), .a_is_nan_o(a_is_nan),
    .b_sign_o(b_sign), .b_exponent_o(b_exponent), .b_significand_o(b_significand),
    .b_is_zero_o(b_is_zero), .b_is_inf_o(b_is_inf), .b_is_nan_o(b_is_nan)
  );

  fpu_mul #(.FmtExpWidth(FmtExpWidth), .FmtSigWidth(FmtSigWidth)) fpu_mul_inst (
    .clk_i, .rst_n_i, .valid_i(unpack_valid),
    .a_sign_i(a_sign), .a_exponent_i(a_exponent), .a_significand_i(a_significand),
    .a_is_zero_i(a_is_zero), .a_is_inf_i(a_is_inf), .a_is_nan_i(a_is_nan),
    .b_sign_i(b_sign), .b_exponent_i(b_exponent), .b_significand_i(b_significand),
    .b_is_zero_i(b_is_zero), .b_is_inf_i(b_is_inf), .b_is_nan_i(b_is_nan),
    .valid_o(mul_valid), .invalid_o(mul_invalid), .sign_o(mul_sign),
    .exponent_o(mul_exponent), .significand_o(mul_significand),
    .is_zero_o(mul_is_zero), .is_inf_o(mul_is_inf), .is_nan_o(mul_is_nan)
  );

  fpu_round_pack #(.FmtExpWidth(FmtExpWidth), .FmtSigWidth(FmtSigWidth)) fpu_round_pack_inst (
    .clk_i, .rst_n_i, .valid_i(mul_valid), .invalid_i(mul_invalid), .sign_i(mul_sign),
    .exponent_i(mul_exponent), .significand_i(mul_significand),
    .is_zero_i(mul_is_zero), .is_inf_i(mul_is_inf), .is_nan_i(mul_is_nan),
    .done_o(done), .result_o(result), .flags_o(flags)
  );

endmodule

// File: test/fpu_mul_tb_checks.svh
task automatic check_word(input string name, input fp_word_t got, input fp_word_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
  end
endtask

task automatic check_flags(input string name, input fp_flags_t got, input fp_flags_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] t=%0t %s: got 4'b%04b, expected 4'b%04b", $time, name, got, exp);
  end
endtask

task automatic check_resp(input string name, input axil_resp_t got, input axil_resp_t exp);
  if (got !== exp) begin
    value_errors++;
    $display("[ERROR] t=%0t %s: got 2'b%02b, expected 2'b%02b", $time, name, got, exp);
  end
endtask

function automatic fp_flags_t make_flags(logic nv, logic of, logic uf, logic nx);
  fp_flags_t f;
  f         = '0;
  f[FlagNv] = nv;
  f[FlagOf] = of;
  f[FlagUf] = uf;
  f[FlagNx] = nx;
  return f;
endfunction

// binary32 product from the 48-bit integer product of the two significands
function automatic void model_mul(input fp_word_t a, input fp_word_t b,
                                  output fp_word_t res, output fp_flags_t flags);
  logic        sign;
  logic        a_zero, a_inf, a_nan, b_zero, b_inf, b_nan;
  logic        bad_op;
  logic [47:0] prod;
  logic [22:0] kept;
  logic        guard;
  logic        sticky;
  int          exp_r;
  sign   = a[31] ^ b[31];
  a_zero = (a[30:23] == 8'h00);
  b_zero = (b[30:23] == 8'h00);
  a_inf  = (a[30:23] == 8'hFF) && (a[22:0] == '0);
  b_inf  = (b[30:23] == 8'hFF) && (b[22:0] == '0);
  a_nan  = (a[30:23] == 8'hFF) && (a[22:0] != '0);
  b_nan  = (b[30:23] == 8'hFF) && (b[22:0] != '0);
  // signaling NaNs and inf times zero
  bad_op = (a_nan && !a[22]) || (b_nan && !b[22]) || (a_inf && b_zero) || (a_zero && b_inf);
  res    = '0;
  flags  = '0;
  if (a_nan || b_nan || bad_op) begin
    res = CanonicalNan;
    flags[FlagNv] = bad_op;
  end else if (a_inf || b_inf) begin
    res = {sign, 8'hFF, 23'd0};
  end else if (a_zero || b_zero) begin
    res = {sign, 31'd0};
  end else begin
    prod  = {1'b1, a[22:0]} * {1'b1, b[22:0]};
    exp_r = int'(a[30:23]) + int'(b[30:23]) - 127;
    if (prod[47]) begin
      exp_r++;
      kept   = prod[46:24];
      guard  = prod[23];
      sticky = |prod[22:0];
    end else begin
      kept   = prod[45:23];
      guard  = prod[22];
      sticky = |prod[21:0];
    end
    if (guard && (sticky || kept[0])) begin
      if (kept == '1) begin
        kept = '0;
        exp_r++;
      end else begin
        kept++;
      end
    end
    if (exp_r >= 255) begin
      res   = {sign, 8'hFF, 23'd0};
      flags = make_flags(1'b0, 1'b1, 1'b0, 1'b1);
    end else if (exp_r < 1) begin
      res   = {sign, 31'd0};
      flags = make_flags(1'b0, 1'b0, 1'b1, 1'b1);
    end else begin
      res = {sign, exp_r[7:0], kept};
      flags[FlagNx] = guard || sticky;
    end
  end
endfunction

// poll the status register until busy clears
task automatic wait_idle(output fp_word_t status);
  axil_resp_t resp;
  int         polls;
  polls = 0;
  do begin
    axil_read(RegStatus, status, resp);
    polls++;
  end while (status[0] && polls < 50);
  if (status[0]) begin
    other_errors++;
    $display("operation did not finish, busy still set after %0d status reads", polls);
  end
  check_resp("RegStatus rresp", resp, RespOkay);
endtask

task automatic run_mul(input string name, input fp_word_t a, input fp_word_t b,
                       input fp_word_t exp_res, input fp_flags_t exp_flags);
  axil_resp_t resp;
  fp_word_t   status;
  fp_word_t   result;
  axil_write(RegOpA, a, 4'hF, resp);
  check_resp({name, " RegOpA bresp"}, resp, RespOkay);
  axil_write(RegOpB, b, 4'hF, resp);
  check_resp({name, " RegOpB bresp"}, resp, RespOkay);
  wait_idle(status);
  axil_read(RegResult, result, resp);
  check_resp({name, " RegResult rresp"}, resp, RespOkay);
  check_word({name, " RegResult"}, result, exp_res);
  check_flags({name, " RegStatus flags"}, fp_flags_t'(status[4:1]), exp_flags);
endtask

task automatic test_exact_products();
  run_mul("1.5*2.0", 32'h3FC0_0000, 32'h4000_0000, 32'h4040_0000, '0);
  run_mul("-1.5*2.0", 32'hBFC0_0000, 32'h4000_0000, 32'hC040_0000, '0);
  run_mul("pi*1.0", 32'h4049_0FDB, 32'h3F80_0000, 32'h4049_0FDB, '0);
  run_mul("1.0*x", 32'h3F80_0000, 32'hC2F6_E979, 32'hC2F6_E979, '0);
endtask

task automatic test_random_operands();
  fp_word_t  a;
  fp_word_t  b;
  fp_word_t  exp_res;
  fp_flags_t exp_flags;
  for (int i = 0; i < NumRandom; i++) begin
    a = $random(seed);
    b = $random(seed);
    // exponent fields in 64..189 keep every product in the normal range
    a[30:23] = 8'(64 + ($unsigned($random(seed)) % 126));
    b[30:23] = 8'(64 + ($unsigned($random(seed)) % 126));
    model_mul(a, b, exp_res, exp_flags);
    run_mul($sformatf("random %0d", i), a, b, exp_res, exp_flags);
  end
endtask

task automatic test_special_cases();
  run_mul("inf*0", 32'h7F80_0000, 32'h0000_0000, CanonicalNan, make_flags(1, 0, 0, 0));
  run_mul("snan*1.0", 32'h7F80_0001, 32'h3F80_0000, CanonicalNan, make_flags(1, 0, 0, 0));
  run_mul("qnan*2.0", 32'h7FC0_0001, 32'h4000_0000, CanonicalNan, '0);
  run_mul("-qnan*2.0", 32'hFFC0_0000, 32'h4000_0000, CanonicalNan, '0);
  run_mul("inf*-2.0", 32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000, '0);
  run_mul("subnormal*2.0", 32'h0000_0001, 32'h4000_0000, 32'h0000_0000, '0);
  run_mul("-subnormal*1.0", 32'h8040_0000, 32'h3F80_0000, 32'h8000_0000, '0);
endtask

task automatic test_range_limits();
  run_mul("max*2.0", 32'h7F7F_FFFF, 32'h4000_0000, 32'h7F80_0000, make_flags(0, 1, 0, 1));
  run_mul("-max*2.0", 32'hFF7F_FFFF, 32'h4000_0000, 32'hFF80_0000, make_flags(0, 1, 0, 1));
  run_mul("minnorm*0.5", 32'h0080_0000, 32'h3F00_0000, 32'h0000_0000, make_flags(0, 0, 1, 1));
endtask

task automatic test_bus_behavior();
  axil_resp_t resp;
  fp_word_t   data;
  fp_word_t   status;
  fp_word_t   exp_res;
  fp_flags_t  exp_flags;
  axil_write(RegOpA, 32'hAABB_CCDD, 4'hF, resp);
  axil_write(RegOpA, 32'h1122_3344, 4'b0101, resp);
  check_resp("RegOpA strobed bresp", resp, RespOkay);
  axil_read(RegOpA, data, resp);
  check_word("RegOpA after strobed write", data, 32'hAA22_CC44);
  axil_write(RegOpB, 32'h5566_7788, 4'hF, resp);
  axil_write(RegOpB, 32'h99AA_BBCC, 4'b1000, resp);
  wait_idle(status);
  axil_read(RegOpB, data, resp);
  check_word("RegOpB after strobed write", data, 32'h9966_7788);

  // read-only and unmapped writes must change nothing
  model_mul(32'hAA22_CC44, 32'h9966_7788, exp_res, exp_flags);
  axil_write(RegResult, 32'hDEAD_BEEF, 4'hF, resp);
  check_resp("RegResult write bresp", resp, RespSlverr);
  axil_write(RegStatus, 32'hFFFF_FFFF, 4'hF, resp);
  check_resp("RegStatus write bresp", resp, RespSlverr);
  axil_write(4'h2, 32'h0BAD_F00D, 4'hF, resp);
  check_resp("unmapped write bresp", resp, RespSlverr);
  axil_read(RegResult, data, resp);
  check_word("RegResult after rejected writes", data, exp_res);
  axil_read(RegStatus, data, resp);
  check_flags("RegStatus flags after rejected writes", fp_flags_t'(data[4:1]), exp_flags);
  axil_read(RegOpA, data, resp);
  check_word("RegOpA after rejected writes", data, 32'hAA22_CC44);
  axil_read(RegOpB, data, resp);
  check_word("RegOpB after rejected writes", data, 32'h9966_7788);

  axil_read(4'h6, data, resp);
  check_word("unmapped rdata", data, '0);
  check_resp("unmapped rresp", resp, RespSlverr);

  // 2.0*3.0 then 2.0*5.0 leaves the later product
  axil_write(RegOpA, 32'h4000_0000, 4'hF, resp);
  axil_write(RegOpB, 32'h4040_0000, 4'hF, resp);
  axil_write(RegOpB, 32'h40A0_0000, 4'hF, resp);
  wait_idle(status);
  axil_read(RegResult, data, resp);
  check_word("RegResult after back-to-back B writes", data, 32'h4120_0000);
  check_flags("RegStatus flags after back-to-back", fp_flags_t'(status[4:1]), '0);
endtask

// File: test/fpu_mul_tb.sv
module fpu_mul_tb import fpu_mul_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NumRandom = 40;
  // random products plus directed and bus-test multiplications
  localparam int NumOps    = NumRandom + 18;
  localparam int WatchNs   = NumOps * 200 + 2000;

  logic       clk_i;
  logic       rst_n_i;
  axil_addr_t s_awaddr_i;
  logic       s_awvalid_i;
  logic       s_awready_o;
  fp_word_t   s_wdata_i;
  logic [3:0] s_wstrb_i;
  logic       s_wvalid_i;
  logic       s_wready_o;
  axil_resp_t s_bresp_o;
  logic       s_bvalid_o;
  logic       s_bready_i;
  axil_addr_t s_araddr_i;
  logic       s_arvalid_i;
  logic       s_arready_o;
  fp_word_t   s_rdata_o;
  axil_resp_t s_rresp_o;
  logic       s_rvalid_o;
  logic       s_rready_i;

  integer seed;
  int     value_errors;
  int     other_errors;

  fpu_mul_top #(
    .FmtExpWidth(FmtExpWidth),
    .FmtSigWidth(FmtSigWidth)
  ) fpu_mul_top_inst (.*);

  `include "fpu_mul_tb_checks.svh"

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // drive AW and W together and wait for the B response
  task automatic axil_write(input axil_addr_t addr, input fp_word_t data,
                            input logic [3:0] strb, output axil_resp_t resp);
    @(posedge clk_i);
    s_awaddr_i  <= addr;
    s_awvalid_i <= 1'b1;
    s_wdata_i   <= data;
    s_wstrb_i   <= strb;
    s_wvalid_i  <= 1'b1;
    do @(negedge clk_i); while (!(s_awready_o && s_wready_o));
    @(posedge clk_i);
    s_awvalid_i <= 1'b0;
    s_wvalid_i  <= 1'b0;
    s_bready_i  <= 1'b1;
    do @(negedge clk_i); while (!s_bvalid_o);
    resp = s_bresp_o;
    @(posedge clk_i);
    s_bready_i <= 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, output fp_word_t data,
                           output axil_resp_t resp);
    @(posedge clk_i);
    s_araddr_i  <= addr;
    s_arvalid_i <= 1'b1;
    s_rready_i  <= 1'b1;
    do @(negedge clk_i); while (!s_arready_o);
    @(posedge clk_i);
    s_arvalid_i <= 1'b0;
    do @(negedge clk_i); while (!s_rvalid_o);
    data = s_rdata_o;
    resp = s_rresp_o;
    @(posedge clk_i);
    s_rready_i <= 1'b0;
  endtask

  // ends a run that stopped making progress
  initial begin
    #(WatchNs);
    $display("watchdog expired after %0d ns, the test sequence did not complete", WatchNs);
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin
    seed         = 80046;
    value_errors = 0;
    other_errors = 0;
    rst_n_i     <= 1'b0;
    s_awaddr_i  <= '0;
    s_awvalid_i <= 1'b0;
    s_wdata_i   <= '0;
    s_wstrb_i   <= '0;
    s_wvalid_i  <= 1'b0;
    s_bready_i  <= 1'b0;
    s_araddr_i  <= '0;
    s_arvalid_i <= 1'b0;
    s_rready_i  <= 1'b0;
    repeat (16) @(posedge clk_i);
    rst_n_i <= 1'b1;

    test_exact_products();
    test_random_operands();
    test_special_cases();
    test_range_limits();
    test_bus_behavior();

    repeat (4) @(posedge clk_i);
    $display("error counts: %0d value mismatches, %0d other failures",
             value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: filelist.f
+incdir+test
logic/fpu_mul_pkg.sv
logic/fpu_unpack.sv
logic/fpu_mul.sv
logic/fpu_round_pack.sv
logic/fpu_mul_axil_regs.sv
logic/fpu_mul_top.sv
test/fpu_mul_tb.sv

// File: Bender.yml
package:
  name: fpu_mul

sources:
  - files:
      - logic/fpu_mul_pkg.sv
      - logic/fpu_unpack.sv
      - logic/fpu_mul.sv
      - logic/fpu_round_pack.sv
      - logic/fpu_mul_axil_regs.sv
      - logic/fpu_mul_top.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/fpu_mul_tb.sv
